// ==== build.f ====
+incdir+rtl
rtl/tmem_pkg.sv
rtl/tmem_if.sv
rtl/req_decode.sv
rtl/tag_ram.sv
rtl/ctrl_regs.sv
rtl/resp_merge.sv
rtl/tagged_mem_sys.sv
test/tmem_assert.sv
test/tb_tagged_mem_sys.sv

// ==== run.sh ====
#!/bin/sh
# compile and run the tagged memory testbench with verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --timescale 1ns/10ps \
  -f build.f --top-module tb_tagged_mem_sys -o tb_sim
status=$?
if [ $status -ne 0 ]; then
  echo "verilator compile failed with status $status"
  exit $status
fi

./obj_dir/tb_sim +verilator+error+limit+100
status=$?
if [ $status -ne 0 ]; then
  echo "simulation failed with status $status"
fi
exit $status

// ==== test/tb_tagged_mem_sys.sv ====
`timescale 1ns/10ps
`include "tmem_params.svh"

module tb_tagged_mem_sys;

  localparam int unsigned NUM_TXN = 800;
  localparam logic [31:0] RAM_BASE = `TMEM_RAM_BASE;
  localparam logic [31:0] REG_BASE = `TMEM_REG_BASE;
  // mapped offsets plus two unused ones
  localparam logic [7:0] REG_OFS [10] = '{`TMEM_REG_CTRL_LO, `TMEM_REG_CTRL_HI,
    `TMEM_REG_GO, `TMEM_REG_STAT, `TMEM_REG_SCR0, `TMEM_REG_SCR1, `TMEM_REG_ERREN,
    `TMEM_REG_IACK, 8'h10, 8'hff};

  logic        clk;
  logic        rst_n;
  logic        req_valid;
  logic [31:0] req_addr;
  logic        req_we;
  logic        req_cap;
  logic [3:0]  req_be;
  logic [32:0] req_wdata;
  logic        req_ready;
  logic        rsp_valid;
  logic [32:0] rsp_rdata;
  logic        rsp_err;
  logic        rsp_ready;
  logic [63:0] ctrl_word;
  logic        ctrl_go;
  logic [3:0]  err_enable_vec;
  logic [2:0]  intr_ack;
  logic        core_busy;
  int unsigned accepted;

  tagged_mem_sys i_tagged_mem_sys (.*);

  always #20 clk = ~clk;

  task automatic abort_run(input string reason);
    $display("TB FAILED");
    $fatal(1, "%s", reason);
  endtask

  // spreads the 16 test words over the whole ram address range
  function automatic logic [`TMEM_AW-1:0] ram_word(input int unsigned idx);
    return {idx[3:0], 6'(idx * 5)};
  endfunction

  // first 16 requests fill the ram words that later traffic reads
  task automatic drive_random_request();
    int unsigned pick;
    pick = $urandom_range(0, 9);
    req_valid <= ($urandom_range(0, 3) != 0);
    req_we    <= 1'($urandom_range(0, 1));
    req_cap   <= 1'($urandom_range(0, 1));
    req_be    <= ($urandom_range(0, 1) != 0) ? 4'hf : 4'($urandom);
    req_wdata <= {1'($urandom), $urandom};
    if (pick < 5)
      req_addr <= RAM_BASE + (32'(ram_word($urandom_range(0, 15))) << 2);
    else if (pick < 8)
      req_addr <= REG_BASE + (32'(REG_OFS[4'($urandom_range(0, 9))]) << 2);
    else
      req_addr <= ((pick == 8) ? RAM_BASE + 32'h1000 : REG_BASE + 32'h400)
        + (32'($urandom_range(0, 255)) << 2);
    if (accepted < 16) begin
      req_valid <= 1'b1;
      req_we    <= 1'b1;
      req_be    <= 4'hf;
      req_addr  <= RAM_BASE + (32'(ram_word(accepted)) << 2);
    end
  endtask

  initial begin
    clk       = 1'b0;
    rst_n     = 1'b0;
    req_valid = 1'b0;
    req_addr  = 32'h0;
    req_we    = 1'b0;
    req_cap   = 1'b0;
    req_be    = 4'h0;
    req_wdata = 33'h0;
    rsp_ready = 1'b0;
    core_busy = 1'b0;
    accepted  = 0;
    void'($urandom(72132));
    repeat (10) @(posedge clk);
    rst_n <= 1'b1;
    while (accepted < NUM_TXN) begin : traffic
      logic fire;
      @(negedge clk);
      fire = req_valid && req_ready;
      @(posedge clk);
      if (fire)
        accepted++;
      if (fire || !req_valid)
        drive_random_request();
      // every third block of 100 runs without back-pressure
      rsp_ready <= ((accepted / 100) % 3 == 0) ? 1'b1 : 1'($urandom_range(0, 1));
      if ($urandom_range(0, 11) == 0)
        core_busy <= ~core_busy;
    end
    req_valid <= 1'b0;
    rsp_ready <= 1'b1;
    @(negedge clk);
    while (rsp_valid)
      @(negedge clk);
    repeat (2) @(negedge clk);
    if (i_tagged_mem_sys.i_tmem_assert.fail_flag) begin
      abort_run("a response or core output check failed");
    end else begin
      $display("TB PASSED");
      $finish;
    end
  end

  always @(negedge clk) begin
    if (i_tagged_mem_sys.i_tmem_assert.fail_flag)
      abort_run("a response or core output check failed");
  end

  initial begin
    #((NUM_TXN * 8 + 10) * 40);
    abort_run("timeout, the transactions did not complete in time");
  end

endmodule

// ==== test/tmem_assert.sv ====
`timescale 1ns/10ps
`include "tmem_params.svh"

module tmem_assert (
  input logic        clk,
  input logic        rst_n,
  input logic        req_valid,
  input logic [31:0] req_addr,
  input logic        req_we,
  input logic        req_cap,
  input logic [3:0]  req_be,
  input logic [32:0] req_wdata,
  input logic        req_ready,
  input logic        rsp_valid,
  input logic [32:0] rsp_rdata,
  input logic        rsp_err,
  input logic        rsp_ready,
  input logic [63:0] ctrl_word,
  input logic        ctrl_go,
  input logic [3:0]  err_enable_vec,
  input logic [2:0]  intr_ack,
  input logic        core_busy
);

  localparam logic [31:0] RAM_BASE = `TMEM_RAM_BASE;
  localparam logic [31:0] REG_BASE = `TMEM_REG_BASE;

  logic [32:0]         sh_mem [0:(1 << `TMEM_AW)-1];
  logic [63:0]         sh_ctrl;
  logic [31:0]         sh_scr0;
  logic [31:0]         sh_scr1;
  logic [3:0]          sh_erren;
  logic                sh_go;
  logic [30:0]         sh_epoch;
  logic                sh_busy_q;
  logic [2:0]          sh_iack;
  // expected responses in request order
  logic [32:0]         q_data [0:3];
  logic                q_err [0:3];
  logic [1:0]          wr_ptr;
  logic [1:0]          rd_ptr;
  logic [2:0]          q_count;
  logic                accept;
  logic                rsp_fire;
  logic                in_ram;
  logic                in_regs;
  logic [`TMEM_AW-1:0] widx;
  logic [7:0]          ofs;
  logic                fail_flag;

  initial fail_flag = 1'b0;

  assign accept   = req_valid && req_ready;
  assign rsp_fire = rsp_valid && rsp_ready;
  assign in_ram   = (req_addr[31:`TMEM_AW+2] == RAM_BASE[31:`TMEM_AW+2]);
  assign in_regs  = (req_addr[31:`TMEM_REG_OFS_W] == REG_BASE[31:`TMEM_REG_OFS_W]);
  assign widx     = req_addr[`TMEM_AW+1:2];
  assign ofs      = req_addr[9:2];

  task automatic record_failure(input string msg);
    fail_flag = 1'b1;
    $error("error %0t: %s", $time, msg);
  endtask

  always @(posedge clk or negedge rst_n) begin : shadow_update
    logic [32:0] exp_word;
    logic [32:0] new_word;
    if (!rst_n) begin
      sh_ctrl   <= 64'h0;
      sh_scr0   <= 32'h0;
      sh_scr1   <= 32'h0;
      sh_erren  <= 4'h0;
      sh_go     <= 1'b0;
      sh_epoch  <= 31'h0;
      sh_busy_q <= 1'b0;
      sh_iack   <= 3'h0;
      wr_ptr    <= 2'd0;
      rd_ptr    <= 2'd0;
      q_count   <= 3'd0;
    end else begin
      exp_word = 33'h0;
      new_word = sh_mem[widx];
      // go clears on busy, epoch counts busy falling edges
      sh_busy_q <= core_busy;
      if (sh_busy_q && !core_busy)
        sh_epoch <= sh_epoch + 31'd1;
      if (core_busy)
        sh_go <= 1'b0;
      sh_iack <= 3'h0;
      if (accept && in_ram && req_we) begin
        for (int i = 0; i < 4; i++)
          if (req_be[i])
            new_word[8*i +: 8] = req_wdata[8*i +: 8];
        // only a full word cap store keeps a tag
        if (req_cap && (req_be == 4'hf))
          new_word[32] = req_wdata[32];
        else if (|req_be)
          new_word[32] = 1'b0;
        sh_mem[widx] <= new_word;
      end else if (accept && in_ram) begin
        exp_word = sh_mem[widx];
      end else if (accept && in_regs && req_we) begin
        case (ofs)
          `TMEM_REG_CTRL_LO: sh_ctrl[31:0]  <= req_wdata[31:0];
          `TMEM_REG_CTRL_HI: sh_ctrl[63:32] <= req_wdata[31:0];
          `TMEM_REG_GO:      sh_go          <= req_wdata[0];
          `TMEM_REG_SCR0:    sh_scr0        <= req_wdata[31:0];
          `TMEM_REG_SCR1:    sh_scr1        <= req_wdata[31:0];
          `TMEM_REG_ERREN:   sh_erren       <= req_wdata[3:0];
          `TMEM_REG_IACK:    sh_iack        <= req_wdata[2:0];
          default: ;
        endcase
      end else if (accept && in_regs) begin
        case (ofs)
          `TMEM_REG_CTRL_LO: exp_word[31:0] = sh_ctrl[31:0];
          `TMEM_REG_CTRL_HI: exp_word[31:0] = sh_ctrl[63:32];
          `TMEM_REG_GO:      exp_word[31:0] = {8'h55, 23'h0, sh_go};
          `TMEM_REG_STAT:    exp_word[31:0] = {sh_epoch, core_busy};
          `TMEM_REG_SCR0:    exp_word[31:0] = sh_scr0;
          `TMEM_REG_SCR1:    exp_word[31:0] = sh_scr1;
          `TMEM_REG_ERREN:   exp_word[31:0] = {28'h0, sh_erren};
          `TMEM_REG_IACK:    exp_word[31:0] = {29'h0, sh_iack};
          default:           exp_word[31:0] = 32'hdead_beef;
        endcase
      end
      // unmapped requests expect err with zero data
      if (accept) begin
        q_data[wr_ptr] <= exp_word;
        q_err[wr_ptr]  <= !(in_ram || in_regs);
        wr_ptr         <= wr_ptr + 2'd1;
      end
      if (rsp_fire)
        rd_ptr <= rd_ptr + 2'd1;
      q_count <= q_count + 3'(accept) - 3'(rsp_fire);
    end
  end

  a_rsp_value: assert property (@(posedge clk) disable iff (!rst_n)
    rsp_fire |-> (rsp_rdata == q_data[rd_ptr]) && (rsp_err == q_err[rd_ptr]))
    else record_failure("response data or err differs from the expected value");

  // no lost or extra responses, at most two in flight
  a_in_flight: assert property (@(posedge clk) disable iff (!rst_n)
    (q_count <= 3'd2) && (rsp_valid == (q_count != 3'd0)))
    else record_failure("rsp_valid does not match the outstanding requests");

  a_latency: assert property (@(posedge clk) disable iff (!rst_n)
    accept |=> rsp_valid)
    else record_failure("rsp_valid not high one cycle after accept");

  a_hold: assert property (@(posedge clk) disable iff (!rst_n)
    (rsp_valid && !rsp_ready) |=> (rsp_valid && $stable(rsp_rdata) && $stable(rsp_err)))
    else record_failure("response changed while stalled");

  a_stall_ready: assert property (@(posedge clk) disable iff (!rst_n)
    (rsp_valid && !rsp_ready) |-> !req_ready)
    else record_failure("req_ready high while response stalled");

  a_core_outputs: assert property (@(posedge clk) disable iff (!rst_n)
    (ctrl_word == sh_ctrl) && (ctrl_go == sh_go) && (err_enable_vec == sh_erren)
      && (intr_ack == sh_iack))
    else record_failure("core side outputs differ from the register model");

endmodule

bind tagged_mem_sys tmem_assert i_tmem_assert (.*);

// ==== rtl/tagged_mem_sys.sv ====
`timescale 1ns/10ps

module tagged_mem_sys (
  input  logic        clk,
  input  logic        rst_n,

  input  logic        req_valid,
  input  logic [31:0] req_addr,
  input  logic        req_we,
  input  logic        req_cap,
  input  logic [3:0]  req_be,
  input  logic [32:0] req_wdata,
  output logic        req_ready,

  output logic        rsp_valid,
  output logic [32:0] rsp_rdata,
  output logic        rsp_err,
  input  logic        rsp_ready,

  output logic [63:0] ctrl_word,
  output logic        ctrl_go,
  output logic [3:0]  err_enable_vec,
  output logic [2:0]  intr_ack,
  input  logic        core_busy
);

  logic miss;

  tmem_req_if ram_req ();
  tmem_req_if regs_req ();
  tmem_rsp_if ram_rsp ();
  tmem_rsp_if regs_rsp ();

  req_decode i_req_decode (
    .clk       (clk),
    .rst_n     (rst_n),
    .req_valid (req_valid),
    .req_addr  (req_addr),
    .req_we    (req_we),
    .req_cap   (req_cap),
    .req_be    (req_be),
    .req_wdata (req_wdata),
    .req_ready (req_ready),
    .ram       (ram_req),
    .regs      (regs_req),
    .miss      (miss)
  );

  tag_ram i_tag_ram (
    .clk   (clk),
    .rst_n (rst_n),
    .req   (ram_req),
    .rsp   (ram_rsp)
  );

  ctrl_regs i_ctrl_regs (
    .clk            (clk),
    .rst_n          (rst_n),
    .req            (regs_req),
    .rsp            (regs_rsp),
    .core_busy      (core_busy),
    .ctrl_word      (ctrl_word),
    .ctrl_go        (ctrl_go),
    .err_enable_vec (err_enable_vec),
    .intr_ack       (intr_ack)
  );

  // merged response, req_ready also feeds the decoder
  resp_merge i_resp_merge (
    .ram       (ram_rsp),
    .regs      (regs_rsp),
    .miss      (miss),
    .rsp_valid (rsp_valid),
    .rsp_rdata (rsp_rdata),
    .rsp_err   (rsp_err),
    .rsp_ready (rsp_ready),
    .req_ready (req_ready)
  );

endmodule

// ==== rtl/resp_merge.sv ====
`timescale 1ns/10ps

module resp_merge (
  tmem_rsp_if.master  ram,
  tmem_rsp_if.master  regs,
  input  logic        miss,
  output logic        rsp_valid,
  output logic [32:0] rsp_rdata,
  output logic        rsp_err,
  input  logic        rsp_ready,
  output logic        req_ready
);

  logic advance;

  // at most one source is valid at a time
  assign rsp_valid = ram.valid | regs.valid | miss;

  always_comb begin
    if (ram.valid) begin
      rsp_rdata = ram.rdata;
      rsp_err   = ram.err;
    end else if (regs.valid) begin
      rsp_rdata = regs.rdata;
      rsp_err   = regs.err;
    end else begin
      // a miss, or nothing presented
      rsp_rdata = 33'h0;
      rsp_err   = miss;
    end
  end

  // pipeline moves when the output slot is empty or draining
  assign advance = ~rsp_valid | rsp_ready;

  assign ram.ready  = advance;
  assign regs.ready = advance;
  assign req_ready  = advance;

endmodule

// ==== rtl/ctrl_regs.sv ====
`timescale 1ns/10ps
`include "tmem_params.svh"

module ctrl_regs (
  input  logic        clk,
  input  logic        rst_n,
  tmem_req_if.slave   req,
  tmem_rsp_if.slave   rsp,
  input  logic        core_busy,
  output logic [63:0] ctrl_word,
  output logic        ctrl_go,
  output logic [3:0]  err_enable_vec,
  output logic [2:0]  intr_ack
);
  import tmem_pkg::*;

  logic [7:0]  ofs;
  logic        wr_en;
  logic        rd_en;
  logic [31:0] wdata;
  logic [31:0] rd_word;
  logic [30:0] epoch;
  logic        busy_q;
  logic [31:0] scratch0;
  logic [31:0] scratch1;

  assign ofs   = req.req.addr[7:0];
  assign wdata = req.req.wdata[31:0];
  assign wr_en = req.sel && (req.req.op != OP_READ);
  assign rd_en = req.sel && (req.req.op == OP_READ);

  // read mux over the register map
  always_comb begin
    case (ofs)
      `TMEM_REG_CTRL_LO: rd_word = ctrl_word[31:0];
      `TMEM_REG_CTRL_HI: rd_word = ctrl_word[63:32];
      `TMEM_REG_GO:      rd_word = {`TMEM_GO_FLAG, 23'h0, ctrl_go};
      `TMEM_REG_STAT:    rd_word = {epoch, core_busy};
      `TMEM_REG_SCR0:    rd_word = scratch0;
      `TMEM_REG_SCR1:    rd_word = scratch1;
      `TMEM_REG_ERREN:   rd_word = {28'h0, err_enable_vec};
      `TMEM_REG_IACK:    rd_word = {29'h0, intr_ack};
      default:           rd_word = `TMEM_BAD_WORD;
    endcase
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      ctrl_word      <= 64'h0;
      scratch0       <= 32'h0;
      scratch1       <= 32'h0;
      err_enable_vec <= 4'h0;
    end else if (wr_en) begin
      // STAT and unused offsets drop the write
      case (ofs)
        `TMEM_REG_CTRL_LO: ctrl_word[31:0]  <= wdata;
        `TMEM_REG_CTRL_HI: ctrl_word[63:32] <= wdata;
        `TMEM_REG_SCR0:    scratch0         <= wdata;
        `TMEM_REG_SCR1:    scratch1         <= wdata;
        `TMEM_REG_ERREN:   err_enable_vec   <= wdata[3:0];
        default: ;
      endcase
    end
  end

  // core side handshake state
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      ctrl_go  <= 1'b0;
      busy_q   <= 1'b0;
      epoch    <= 31'h0;
      intr_ack <= 3'h0;
    end else begin
      // a GO write in the same cycle wins over the self clear
      if (wr_en && (ofs == `TMEM_REG_GO))
        ctrl_go <= wdata[0];
      else if (core_busy)
        ctrl_go <= 1'b0;

      busy_q <= core_busy;
      // engine finished a run
      if (busy_q && !core_busy)
        epoch <= epoch + 31'd1;

      // single cycle pulse
      if (wr_en && (ofs == `TMEM_REG_IACK))
        intr_ack <= wdata[2:0];
      else
        intr_ack <= 3'h0;
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      rsp.valid <= 1'b0;
    end else if (rsp.ready) begin
      rsp.valid <= req.sel;
    end
  end

  // register reads never carry a tag, writes return zero
  always_ff @(posedge clk) begin
    if (rsp.ready && req.sel) begin
      rsp.rdata <= rd_en ? {1'b0, rd_word} : 33'h0;
    end
  end

  assign rsp.err = 1'b0;

endmodule

// ==== rtl/tag_ram.sv ====
`timescale 1ns/10ps
`include "tmem_params.svh"

module tag_ram (
  input  logic        clk,
  input  logic        rst_n,
  tmem_req_if.slave   req,
  tmem_rsp_if.slave   rsp
);
  import tmem_pkg::*;

  localparam int unsigned DEPTH = 2 ** `TMEM_AW;

  // bit 32 holds the capability tag
  logic [32:0] mem [0:DEPTH-1];

  logic                is_write;
  logic [`TMEM_AW-1:0] waddr;

  assign is_write = (req.req.op != OP_READ);
  assign waddr    = req.req.addr;

  always_ff @(posedge clk) begin
    if (req.sel && is_write) begin
      for (int i = 0; i < 4; i++) begin
        if (req.req.be[i])
          mem[waddr][8*i +: 8] <= req.req.wdata[8*i +: 8];
      end
      // tag survives only a full word cap store, any partial or plain store clears it
      if ((req.req.op == OP_CAP_WRITE) && (req.req.be == 4'hf))
        mem[waddr][32] <= req.req.wdata[32];
      else if (|req.req.be)
        mem[waddr][32] <= 1'b0;
    end
  end

  // output register holds while the merger stalls
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      rsp.valid <= 1'b0;
    end else if (rsp.ready) begin
      rsp.valid <= req.sel;
    end
  end

  always_ff @(posedge clk) begin
    if (rsp.ready && req.sel) begin
      if (is_write)
        rsp.rdata <= 33'h0;
      else
        rsp.rdata <= mem[waddr];
    end
  end

  // no error source in the ram
  assign rsp.err = 1'b0;

endmodule

// ==== rtl/req_decode.sv ====
`timescale 1ns/10ps
`include "tmem_params.svh"

module req_decode (
  input  logic              clk,
  input  logic              rst_n,
  input  logic              req_valid,
  input  logic [31:0]       req_addr,
  input  logic              req_we,
  input  logic              req_cap,
  input  logic [3:0]        req_be,
  input  logic [32:0]       req_wdata,
  input  logic              req_ready,
  tmem_req_if.master        ram,
  tmem_req_if.master        regs,
  output logic              miss
);
  import tmem_pkg::*;

  localparam int unsigned RAM_LSB = `TMEM_AW + 2;
  localparam int unsigned REG_LSB = `TMEM_REG_OFS_W;
  localparam logic [31:0] RAM_BASE = `TMEM_RAM_BASE;
  localparam logic [31:0] REG_BASE = `TMEM_REG_BASE;

  logic     accept;
  tgt_t     tgt;
  op_t      op;
  mem_req_t base_req;

  assign accept = req_valid & req_ready;

  // window match on the upper address bits, everything above the window is zero
  always_comb begin
    if (req_addr[31:RAM_LSB] == RAM_BASE[31:RAM_LSB])
      tgt = TGT_RAM;
    else if (req_addr[31:REG_LSB] == REG_BASE[31:REG_LSB])
      tgt = TGT_REGS;
    else
      tgt = TGT_NONE;
  end

  always_comb begin
    if (!req_we)
      op = OP_READ;
    else if (req_cap)
      op = OP_CAP_WRITE;
    else
      op = OP_WRITE;
  end

  always_comb begin
    base_req.op    = op;
    base_req.be    = req_be;
    base_req.addr  = req_addr[RAM_LSB-1:2];
    base_req.wdata = req_wdata;
  end

  assign ram.sel = accept && (tgt == TGT_RAM);
  assign ram.req = base_req;

  // register window offset is only 8 bits, zero extended
  assign regs.sel = accept && (tgt == TGT_REGS);
  always_comb begin
    regs.req      = base_req;
    regs.req.addr = `TMEM_AW'(req_addr[REG_LSB-1:2]);
  end

  // unmapped access completes as an error response one cycle later
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      miss <= 1'b0;
    end else if (req_ready) begin
      miss <= accept && (tgt == TGT_NONE);
    end
  end

endmodule

// ==== rtl/tmem_if.sv ====
`timescale 1ns/10ps

// request strobe from the decoder to one target
interface tmem_req_if;
  import tmem_pkg::*;

  // high only in the accept cycle
  logic     sel;
  mem_req_t req;

  modport master (
    output sel,
    output req
  );

  modport slave (
    input sel,
    input req
  );

endinterface

// registered result from one target to the response merger
interface tmem_rsp_if;

  logic        valid;
  logic [32:0] rdata;
  logic        err;
  // target loads its output register only while ready is high
  logic        ready;

  modport slave (
    output valid,
    output rdata,
    output err,
    input  ready
  );

  modport master (
    input  valid,
    input  rdata,
    input  err,
    output ready
  );

endinterface

// ==== rtl/tmem_pkg.sv ====
`include "tmem_params.svh"

package tmem_pkg;

  // request opcode, cap writes carry a valid tag in wdata[32]
  typedef enum logic [1:0] {
    OP_READ      = 2'd0,
    OP_WRITE     = 2'd1,
    OP_CAP_WRITE = 2'd2
  } op_t;

  // decoded target window
  typedef enum logic [1:0] {
    TGT_RAM  = 2'd0,
    TGT_REGS = 2'd1,
    TGT_NONE = 2'd2
  } tgt_t;

  // request as seen by a target
  // addr is the word address inside the window, regs use the low 8 bits
  typedef struct packed {
    op_t                 op;
    logic [3:0]          be;
    logic [`TMEM_AW-1:0] addr;
    logic [32:0]         wdata;
  } mem_req_t;

endpackage

// ==== rtl/tmem_params.svh ====
`ifndef TMEM_PARAMS_SVH
`define TMEM_PARAMS_SVH

// tag ram word address width, 1024 words
`define TMEM_AW 10

// byte base addresses of the two windows
`define TMEM_RAM_BASE 32'h8000_0000
`define TMEM_REG_BASE 32'h8380_0000

// register window spans 256 words, so the byte offset is 10 bits wide
`define TMEM_REG_OFS_W 10

// register word offsets
`define TMEM_REG_CTRL_LO 8'h00
`define TMEM_REG_CTRL_HI 8'h01
`define TMEM_REG_GO      8'h02
`define TMEM_REG_STAT    8'h03
`define TMEM_REG_SCR0    8'h20
`define TMEM_REG_SCR1    8'h21
`define TMEM_REG_ERREN   8'h40
`define TMEM_REG_IACK    8'h41

// read value for unused register offsets
`define TMEM_BAD_WORD 32'hdead_beef

// presence flag in the upper byte of the go register
`define TMEM_GO_FLAG 8'h55

`endif
